/* flist.f */
+incdir+sim
hdl/rsa_pkg.sv
hdl/rsa_reg_pkg.sv
hdl/mont_mul.sv
hdl/mod_pre.sv
hdl/rsa_core.sv
hdl/rsa_regs.sv
hdl/rsa_top.sv
sim/rsa_tb.sv

/* Makefile */
# Verilator build and run for the RSA engine testbench
# any variable can be overridden, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= rsa_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal
FAIL_MSG  ?= TEST RESULT: FAIL

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hdl/*.sv sim/*.sv sim/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/rsa_model.svh */
`ifndef RSA_MODEL_SVH
`define RSA_MODEL_SVH

// x * y mod n by shift and add over the bits of y
// x must already be below n
function automatic logic [WIDTH-1:0] mod_mul(
	input logic [WIDTH-1:0] x,
	input logic [WIDTH-1:0] y,
	input logic [WIDTH-1:0] n
);
	logic [WIDTH+1:0] acc; // two spare bits so doubling never overflows
	acc = '0;
	for (int i = WIDTH - 1; i >= 0; i--) begin
		acc = acc << 1;
		if (acc >= {2'b00, n})
			acc = acc - {2'b00, n};
		if (y[i]) begin
			acc = acc + {2'b00, x};
			if (acc >= {2'b00, n})
				acc = acc - {2'b00, n};
		end
	end
	return acc[WIDTH-1:0];
endfunction

// a^d mod n, key scanned from the top bit down
function automatic logic [WIDTH-1:0] mod_exp(
	input logic [WIDTH-1:0] a,
	input logic [WIDTH-1:0] d,
	input logic [WIDTH-1:0] n
);
	logic [WIDTH-1:0] r;
	r = WIDTH'(1);
	for (int i = WIDTH - 1; i >= 0; i--) begin
		r = mod_mul(r, r, n);
		if (d[i])
			r = mod_mul(r, a, n);
	end
	return r;
endfunction

`endif

/* sim/rsa_tb.sv */
`timescale 1ns/100ps

module rsa_tb
	import rsa_reg_pkg::*;
();

	localparam int WIDTH      = 256;
	localparam int NWORDS     = WIDTH / 32;
	localparam int N_RANDOM   = 4;
	localparam int TOTAL_JOBS = N_RANDOM + 6; // three edge keys, busy start, operand pair
	localparam int TIMEOUT_CYCLES = TOTAL_JOBS * (WIDTH + 5) * (WIDTH + 4) + 5000;

	logic        i_clk;
	logic        i_rst;
	host_wr_t    i_host;
	logic [7:0]  i_rd_addr;
	logic [31:0] o_rd_data;
	logic        o_done;

	int errors;
	int checks;
	int done_pulses;

	`include "rsa_model.svh"

	rsa_top #(.WIDTH(WIDTH)) DUT (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_host    (i_host),
		.i_rd_addr (i_rd_addr),
		.o_rd_data (o_rd_data),
		.o_done    (o_done)
	);

	always #50 i_clk = ~i_clk;

	always @(negedge i_clk) begin
		if (o_done)
			done_pulses++; // interrupt line, one pulse per finished run
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic write_word(input logic [7:0] addr, input logic [31:0] data);
		@(posedge i_clk);
		#10;
		i_host.wr   = 1'b1;
		i_host.addr = addr;
		i_host.data = data;
		@(posedge i_clk);
		#10;
		i_host.wr = 1'b0;
	endtask

	// read is combinational, sampled mid cycle
	task automatic read_word(input logic [7:0] addr, output logic [31:0] data);
		@(posedge i_clk);
		#10;
		i_rd_addr = addr;
		@(negedge i_clk);
		data = o_rd_data;
	endtask

	task automatic load_job(input logic [WIDTH-1:0] n, input logic [WIDTH-1:0] d,
		input logic [WIDTH-1:0] a);
		for (int i = 0; i < NWORDS; i++) begin
			write_word(REG_N_BASE + 8'(i), n[i*32 +: 32]);
			write_word(REG_D_BASE + 8'(i), d[i*32 +: 32]);
			write_word(REG_A_BASE + 8'(i), a[i*32 +: 32]);
		end
	endtask

	task automatic wait_busy();
		logic [31:0] status;
		int          tries;
		status = '0;
		tries  = 0;
		while (!status[STAT_BUSY_BIT] && tries < 8) begin
			read_word(REG_STATUS, status);
			tries++;
		end
		if (!status[STAT_BUSY_BIT]) begin
			errors++;
			$display("core never reported busy after the start command");
		end
	endtask

	task automatic wait_idle();
		logic [31:0] status;
		read_word(REG_STATUS, status);
		while (status[STAT_BUSY_BIT]) begin
			read_word(REG_STATUS, status);
		end
	endtask

	task automatic check_status(input string label, input logic [31:0] expected);
		logic [31:0] word;
		read_word(REG_STATUS, word);
		check_value({label, " status"}, word, expected);
	endtask

	task automatic check_result(input string label, input logic [WIDTH-1:0] expected);
		logic [31:0] word;
		for (int i = 0; i < NWORDS; i++) begin
			read_word(REG_RES_BASE + 8'(i), word);
			check_value($sformatf("%s res[%0d]", label, i), word, expected[i*32 +: 32]);
		end
	endtask

	// operands must already sit in the registers
	task automatic run_job(input string label, input logic [WIDTH-1:0] expected);
		write_word(REG_CMD, 32'h1);
		wait_busy();
		wait_idle();
		check_status(label, 32'h2); // idle with sticky done
		check_result(label, expected);
	endtask

	function automatic logic [WIDTH-1:0] rand_value();
		logic [WIDTH-1:0] v;
		for (int i = 0; i < NWORDS; i++) begin
			v[i*32 +: 32] = $urandom;
		end
		return v;
	endfunction

	function automatic logic [WIDTH-1:0] rand_modulus();
		logic [WIDTH-1:0] v;
		v = rand_value();
		v[WIDTH-1] = 1'b1;
		v[0] = 1'b1;
		return v;
	endfunction

	function automatic logic [WIDTH-1:0] rand_base(input logic [WIDTH-1:0] n);
		logic [WIDTH-1:0] v;
		v = rand_value();
		if (v >= n)
			v[WIDTH-1] = 1'b0; // n has its top bit set, so this lands below n
		return v;
	endfunction

	initial begin
		logic [WIDTH-1:0] n;
		logic [WIDTH-1:0] d;
		logic [WIDTH-1:0] a;
		logic [WIDTH-1:0] n2;
		logic [WIDTH-1:0] d2;
		logic [WIDTH-1:0] a2;
		int               pulses;
		void'($urandom(22));
		i_clk     = 1'b0;
		i_rst     = 1'b1;
		i_host    = '0;
		i_rd_addr = '0;
		repeat (16) @(posedge i_clk);
		#10;
		i_rst = 1'b0;

		check_status("reset", 32'h0);
		check_result("reset", '0);

		for (int j = 0; j < N_RANDOM; j++) begin
			n = rand_modulus();
			d = rand_value();
			a = rand_base(n);
			load_job(n, d, a);
			run_job($sformatf("random %0d", j), mod_exp(a, d, n));
		end

		n = rand_modulus();
		a = rand_base(n);
		load_job(n, '0, a);
		run_job("key zero", WIDTH'(1));
		load_job(n, WIDTH'(1), a);
		run_job("key one", a);
		d = rand_value() | WIDTH'(1);
		load_job(n, d, '0);
		run_job("base zero", '0);

		// second command while busy has to be dropped
		n = rand_modulus();
		d = rand_value();
		a = rand_base(n);
		load_job(n, d, a);
		pulses = done_pulses;
		write_word(REG_CMD, 32'h1);
		wait_busy();
		write_word(REG_CMD, 32'h1);
		wait_idle();
		repeat (WIDTH) @(posedge i_clk);
		check_value("done pulses", 32'(done_pulses - pulses), 32'd1);
		check_status("busy start", 32'h2);
		check_result("busy start", mod_exp(a, d, n));

		// new operands written mid run, used only by the next run
		n  = rand_modulus();
		d  = rand_value();
		a  = rand_base(n);
		n2 = rand_modulus();
		d2 = rand_value();
		a2 = rand_base(n2);
		load_job(n, d, a);
		write_word(REG_CMD, 32'h1);
		wait_busy();
		check_status("sticky clear", 32'h1);
		load_job(n2, d2, a2);
		wait_idle();
		check_status("sticky set", 32'h2);
		check_result("old operands", mod_exp(a, d, n));
		run_job("new operands", mod_exp(a2, d2, n2));

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge i_clk);
		$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* hdl/rsa_top.sv */
`timescale 1ns/100ps

module rsa_top
	import rsa_pkg::*;
	import rsa_reg_pkg::*;
#(
	parameter int WIDTH = 256
) (
	input  logic        i_clk,
	input  logic        i_rst,
	input  host_wr_t    i_host,
	input  logic [7:0]  i_rd_addr,
	output logic [31:0] o_rd_data,
	output logic        o_done    // completion pulse, usable as an interrupt
);

	rsa_job_t         job;
	logic             start;
	logic             busy;
	logic [WIDTH-1:0] result;

	rsa_regs #(.WIDTH(WIDTH)) u_regs (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_host    (i_host),
		.i_rd_addr (i_rd_addr),
		.o_rd_data (o_rd_data),
		.o_job     (job),
		.o_start   (start),
		.i_busy    (busy),
		.i_done    (o_done),
		.i_result  (result)
	);

	rsa_core #(.WIDTH(WIDTH)) u_core (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (start),
		.i_job    (job),
		.o_result (result),
		.o_busy   (busy),
		.o_done   (o_done)
	);

endmodule

/* hdl/rsa_regs.sv */
`timescale 1ns/100ps

// host register block, word writes in and combinational word reads out
module rsa_regs
	import rsa_pkg::*;
	import rsa_reg_pkg::*;
#(
	parameter int WIDTH = 256
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  host_wr_t         i_host,
	input  logic [7:0]       i_rd_addr,
	output logic [31:0]      o_rd_data,
	output rsa_job_t         o_job,
	output logic             o_start,
	input  logic             i_busy,
	input  logic             i_done,
	input  logic [WIDTH-1:0] i_result
);

	localparam int NWORDS = WIDTH / 32;

	logic [31:0] n_w   [NWORDS];
	logic [31:0] d_w   [NWORDS];
	logic [31:0] a_w   [NWORDS];
	logic [31:0] res_w [NWORDS];
	logic        done_r; // sticky until the next start
	logic        cmd_go;

	// true when addr falls inside the used words of a region
	function automatic logic in_region(input logic [7:0] addr, input logic [7:0] base);
		return (addr >= base) && (addr < base + 8'(NWORDS));
	endfunction

	assign cmd_go = i_host.wr && (i_host.addr == REG_CMD) && i_host.data[CMD_START_BIT];

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			for (int i = 0; i < NWORDS; i++) begin
				n_w[i]   <= '0;
				d_w[i]   <= '0;
				a_w[i]   <= '0;
				res_w[i] <= '0;
			end
			o_start <= 1'b0;
			done_r  <= 1'b0;
		end else begin
			if (i_host.wr) begin
				if (in_region(i_host.addr, REG_N_BASE)) n_w[i_host.addr[2:0]] <= i_host.data;
				if (in_region(i_host.addr, REG_D_BASE)) d_w[i_host.addr[2:0]] <= i_host.data;
				if (in_region(i_host.addr, REG_A_BASE)) a_w[i_host.addr[2:0]] <= i_host.data;
			end
			o_start <= cmd_go && !i_busy && !o_start; // dropped while a run is on
			if (o_start) begin
				done_r <= 1'b0;
			end else if (i_done) begin
				done_r <= 1'b1;
				for (int i = 0; i < NWORDS; i++) begin
					res_w[i] <= i_result[i*32 +: 32];
				end
			end
		end
	end

	always_comb begin
		o_job = '0; // upper words stay zero below MAX_WIDTH
		for (int i = 0; i < NWORDS; i++) begin
			o_job.n[i*32 +: 32] = n_w[i];
			o_job.d[i*32 +: 32] = d_w[i];
			o_job.a[i*32 +: 32] = a_w[i];
		end
	end

	always_comb begin
		o_rd_data = '0;
		if (in_region(i_rd_addr, REG_N_BASE)) begin
			o_rd_data = n_w[i_rd_addr[2:0]];
		end else if (in_region(i_rd_addr, REG_D_BASE)) begin
			o_rd_data = d_w[i_rd_addr[2:0]];
		end else if (in_region(i_rd_addr, REG_A_BASE)) begin
			o_rd_data = a_w[i_rd_addr[2:0]];
		end else if (in_region(i_rd_addr, REG_RES_BASE)) begin
			o_rd_data = res_w[i_rd_addr[2:0]];
		end else if (i_rd_addr == REG_STATUS) begin
			o_rd_data[STAT_BUSY_BIT] = i_busy;
			o_rd_data[STAT_DONE_BIT] = done_r;
		end
	end

endmodule

/* hdl/rsa_core.sv */
`timescale 1ns/100ps

// right-to-left square and multiply over all key bits
// accumulator stays in the plain domain, base in the montgomery domain
module rsa_core
	import rsa_pkg::*;
#(
	parameter int WIDTH = 256
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_start,
	input  rsa_job_t         i_job,
	output logic [WIDTH-1:0] o_result,
	output logic             o_busy,
	output logic             o_done
);

	localparam int CW = cnt_width(WIDTH);
	localparam logic [CW-1:0] LAST_BIT = CW'(WIDTH - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_PRE,
		S_LAUNCH,
		S_WAIT,
		S_UPDATE
	} state_t;

	state_t           state_r;
	logic [CW-1:0]    bit_r;
	logic [WIDTH-1:0] n_r;
	logic [WIDTH-1:0] d_r;    // key, shifted so bit 0 is the current one
	logic [WIDTH-1:0] base_r; // a^(2^k) in the domain
	logic [WIDTH-1:0] acc_r;
	logic [WIDTH-1:0] res_r;

	logic             pre_start;
	logic             pre_done;
	logic [WIDTH-1:0] pre_res;
	logic             sq_start;
	logic             sq_done;
	logic [WIDTH-1:0] sq_res;
	logic             acc_start;
	logic [WIDTH-1:0] acc_res;
	logic             last_bit;

	assign pre_start = i_start && (state_r == S_IDLE);
	assign sq_start  = (state_r == S_LAUNCH);
	assign acc_start = sq_start && d_r[0]; // multiply only on a set key bit
	assign last_bit  = (bit_r == LAST_BIT);

	assign o_busy   = (state_r != S_IDLE);
	assign o_done   = (state_r == S_UPDATE) && last_bit;
	assign o_result = res_r;

	mod_pre #(.WIDTH(WIDTH)) u_pre (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (pre_start),
		.i_n      (i_job.n[WIDTH-1:0]),
		.i_b      (i_job.a[WIDTH-1:0]),
		.o_result (pre_res),
		.o_done   (pre_done)
	);

	mont_mul #(.WIDTH(WIDTH)) u_mul_acc (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (acc_start),
		.i_n      (n_r),
		.i_a      (acc_r),
		.i_b      (base_r),
		.o_result (acc_res),
		.o_done   () // finishes together with u_mul_sq
	);

	mont_mul #(.WIDTH(WIDTH)) u_mul_sq (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (sq_start),
		.i_n      (n_r),
		.i_a      (base_r),
		.i_b      (base_r),
		.o_result (sq_res),
		.o_done   (sq_done)
	);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r <= S_IDLE;
			bit_r   <= '0;
		end else begin
			case (state_r)
				S_IDLE: begin
					if (i_start) begin
						state_r <= S_PRE;
						bit_r   <= '0;
					end
				end
				S_PRE: begin
					if (pre_done) state_r <= S_LAUNCH;
				end
				S_LAUNCH: state_r <= S_WAIT;
				S_WAIT: begin
					if (sq_done) state_r <= S_UPDATE;
				end
				S_UPDATE: begin
					if (last_bit) begin
						state_r <= S_IDLE;
					end else begin
						state_r <= S_LAUNCH;
						bit_r   <= bit_r + 1'b1;
					end
				end
				default: state_r <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		case (state_r)
			S_IDLE: begin
				if (i_start) begin // job copied here, later writes don't matter
					n_r   <= i_job.n[WIDTH-1:0];
					d_r   <= i_job.d[WIDTH-1:0];
					acc_r <= WIDTH'(1); // plain one, not the domain one
				end
			end
			S_PRE: begin
				if (pre_done) base_r <= pre_res;
			end
			S_WAIT: begin
				if (sq_done) begin
					base_r <= sq_res;
					if (d_r[0]) acc_r <= acc_res;
					if (last_bit) res_r <= d_r[0] ? acc_res : acc_r;
				end
			end
			S_UPDATE: d_r <= d_r >> 1;
			default: ;
		endcase
	end

endmodule

/* hdl/mod_pre.sv */
`timescale 1ns/100ps

// b * 2^WIDTH mod n, moves the base into the montgomery domain
module mod_pre
	import rsa_pkg::*;
#(
	parameter int WIDTH = 256
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_start,
	input  logic [WIDTH-1:0] i_n,
	input  logic [WIDTH-1:0] i_b,
	output logic [WIDTH-1:0] o_result,
	output logic             o_done
);

	localparam int CW = cnt_width(WIDTH);
	localparam logic [CW-1:0] LAST = CW'(WIDTH - 1);

	logic             run_r;
	logic [CW-1:0]    cnt_r;
	logic [WIDTH-1:0] val_r; // always below n
	logic [WIDTH-1:0] n_r;
	logic [WIDTH:0]   dbl;
	logic [WIDTH:0]   dif;
	logic [WIDTH-1:0] nxt;

	always_comb begin
		dbl = {val_r, 1'b0};
		dif = dbl - {1'b0, n_r};
		nxt = (dbl >= {1'b0, n_r}) ? dif[WIDTH-1:0] : dbl[WIDTH-1:0];
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			run_r  <= 1'b0;
			cnt_r  <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				run_r <= 1'b1;
				cnt_r <= '0;
			end else if (run_r) begin
				cnt_r <= cnt_r + 1'b1;
				if (cnt_r == LAST) begin // last doubling also loads the output
					run_r  <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			val_r <= i_b;
			n_r   <= i_n;
		end else if (run_r) begin
			val_r <= nxt;
			if (cnt_r == LAST) begin
				o_result <= nxt;
			end
		end
	end

endmodule

/* hdl/mont_mul.sv */
`timescale 1ns/100ps

// montgomery product a * b * 2^-WIDTH mod n, one bit of a per cycle
// needs n odd and a, b below n
module mont_mul
	import rsa_pkg::*;
#(
	parameter int WIDTH = 256
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_start,
	input  logic [WIDTH-1:0] i_n,
	input  logic [WIDTH-1:0] i_a,
	input  logic [WIDTH-1:0] i_b,
	output logic [WIDTH-1:0] o_result,
	output logic             o_done
);

	localparam int CW = cnt_width(WIDTH);
	localparam logic [CW-1:0] LAST = CW'(WIDTH);

	logic             run_r;
	logic [CW-1:0]    cnt_r;
	logic [WIDTH+1:0] sum_r;   // partial sum, stays below 2n
	logic [WIDTH-1:0] a_r;     // shifts right, bit 0 is the current bit
	logic [WIDTH-1:0] b_r;
	logic [WIDTH-1:0] n_r;
	logic [WIDTH+1:0] sum_add;
	logic [WIDTH+1:0] sum_odd;
	logic [WIDTH+1:0] sum_fin;

	always_comb begin
		sum_add = sum_r + (a_r[0] ? {2'b00, b_r} : '0);
		sum_odd = sum_add[0] ? sum_add + {2'b00, n_r} : sum_add; // make it even
		// one subtract is enough since the sum is below 2n
		sum_fin = (sum_r >= {2'b00, n_r}) ? sum_r - {2'b00, n_r} : sum_r;
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			run_r  <= 1'b0;
			cnt_r  <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				run_r <= 1'b1;
				cnt_r <= '0;
			end else if (run_r) begin
				if (cnt_r == LAST) begin
					run_r  <= 1'b0;
					o_done <= 1'b1;
				end else begin
					cnt_r <= cnt_r + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			sum_r <= '0;
			a_r   <= i_a;
			b_r   <= i_b;
			n_r   <= i_n;
		end else if (run_r) begin
			if (cnt_r == LAST) begin
				o_result <= sum_fin[WIDTH-1:0];
			end else begin
				sum_r <= sum_odd >> 1; // exact halving
				a_r   <= a_r >> 1;
			end
		end
	end

endmodule

/* hdl/rsa_reg_pkg.sv */
package rsa_reg_pkg;

	// word addresses in 32-bit words
	localparam logic [7:0] REG_N_BASE   = 8'd0;
	localparam logic [7:0] REG_D_BASE   = 8'd8;
	localparam logic [7:0] REG_A_BASE   = 8'd16;
	localparam logic [7:0] REG_RES_BASE = 8'd24; // read only
	localparam logic [7:0] REG_CMD      = 8'd32;
	localparam logic [7:0] REG_STATUS   = 8'd33;

	// bit positions inside the command and status words
	localparam int CMD_START_BIT  = 0;
	localparam int STAT_BUSY_BIT  = 0;
	localparam int STAT_DONE_BIT  = 1;

	// host write with a one-cycle strobe per word
	typedef struct packed {
		logic        wr;
		logic [7:0]  addr;
		logic [31:0] data;
	} host_wr_t;

endpackage

/* hdl/rsa_pkg.sv */
package rsa_pkg;

	// upper bound for the operand width, the job struct is sized to this
	localparam int MAX_WIDTH = 256;

	// one exponentiation job as the register block hands it to the core
	// modules use only the low WIDTH bits of each field
	typedef struct packed {
		logic [MAX_WIDTH-1:0] n; // modulus, odd
		logic [MAX_WIDTH-1:0] d; // private key
		logic [MAX_WIDTH-1:0] a; // ciphertext, below n
	} rsa_job_t;

	// bits needed to hold a count from 0 up to and including width
	function automatic int cnt_width(input int width);
		int bits;
		bits = 1;
		while ((1 << bits) <= width) begin
			bits++;
		end
		return bits;
	endfunction

endpackage
